// ==== Makefile ====
# Verilator build and run for the DRAM FIFO testbench
SIM       = verilator
SIM_FLAGS = --binary --assert -j 0
TOP       = tb_dram_fifo
FILELIST  = src.f
BUILD_DIR = obj_dir

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build and run the simulation, fails on a failing run"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(SIM) $(SIM_FLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)

// ==== src.f ====
+incdir+verilog
verilog/dram_fifo_pkg.sv
verilog/fifo_settings.sv
verilog/stage_fifo.sv
verilog/burst_scheduler.sv
verilog/fifo_level_tracker.sv
verilog/dram_fifo_top.sv
verif/dram_model.sv
verif/tb_dram_fifo.sv

// ==== verif/dram_model.sv ====
// Memory behind the burst ports
// One write burst and one read burst in flight at a time, each port on its own
// Every accepted request is logged, o_miss sticks once a read finds no data
`timescale 1ns/1ps
`include "dram_fifo_consts.svh"

module dram_model import dram_fifo_pkg::*; (
   input  logic                  dram_clk,
   input  logic                  i_flush,           // Drops any burst in flight
   input  burst_req_t            i_wr_req,
   input  logic                  i_wr_req_valid,
   output logic                  o_wr_req_ready,
   input  logic [`DF_DWIDTH-1:0] i_wr_data,
   input  logic                  i_wr_data_valid,
   output logic                  o_wr_data_ready,
   output logic                  o_wr_done,
   input  burst_req_t            i_rd_req,
   input  logic                  i_rd_req_valid,
   output logic                  o_rd_req_ready,
   output logic [`DF_DWIDTH-1:0] o_rd_data,
   output logic                  o_rd_data_valid,
   input  logic                  i_rd_data_ready,
   output logic                  o_rd_done,
   output logic                  o_miss
);

   localparam int S_IDLE = 0;
   localparam int S_DATA = 1;   // Moving words
   localparam int S_DONE = 2;   // Done pulse on the port

   logic [`DF_DWIDTH-1:0] mem [logic [`DF_AWIDTH-1:0]];   // Indexed by word address
   burst_req_t            wr_log [$];
   burst_req_t            rd_log [$];
   burst_req_t            wr_cur;
   burst_req_t            rd_cur;
   int                    wr_state;
   int                    rd_state;
   logic [8:0]            wr_beats;   // Words moved in this burst
   logic [8:0]            rd_beats;

   initial begin : serve
      logic [`DF_AWIDTH-1:0] rd_index;
      o_wr_req_ready  = 1'b0;
      o_wr_data_ready = 1'b0;
      o_wr_done       = 1'b0;
      o_rd_req_ready  = 1'b0;
      o_rd_data       = '0;
      o_rd_data_valid = 1'b0;
      o_rd_done       = 1'b0;
      o_miss          = 1'b0;
      wr_state        = S_IDLE;
      rd_state        = S_IDLE;
      wr_beats        = '0;
      rd_beats        = '0;
      forever begin
         ////////////////////////////////////////////////
         // Rising edge, handshakes complete
         ////////////////////////////////////////////////
         @(posedge dram_clk);
         if (i_flush) begin
            wr_state = S_IDLE;
            rd_state = S_IDLE;
         end else begin
            case (wr_state)
               S_IDLE: begin
                  if (i_wr_req_valid && o_wr_req_ready) begin
                     wr_cur   = i_wr_req;
                     wr_log.push_back(i_wr_req);
                     wr_beats = '0;
                     wr_state = S_DATA;
                  end
               end
               S_DATA: begin
                  if (i_wr_data_valid && o_wr_data_ready) begin
                     mem[(wr_cur.addr >> `DF_WORD_SHIFT) + `DF_AWIDTH'(wr_beats)] = i_wr_data;
                     wr_beats = wr_beats + 9'd1;
                     if (wr_beats == 9'(wr_cur.count) + 9'd1) wr_state = S_DONE;
                  end
               end
               default: wr_state = S_IDLE;   // Done seen on this edge
            endcase
            case (rd_state)
               S_IDLE: begin
                  if (i_rd_req_valid && o_rd_req_ready) begin
                     rd_cur   = i_rd_req;
                     rd_log.push_back(i_rd_req);
                     rd_beats = '0;
                     rd_state = S_DATA;
                  end
               end
               S_DATA: begin
                  if (o_rd_data_valid && i_rd_data_ready) begin
                     rd_beats = rd_beats + 9'd1;
                     if (rd_beats == 9'(rd_cur.count) + 9'd1) rd_state = S_DONE;
                  end
               end
               default: rd_state = S_IDLE;
            endcase
         end
         ////////////////////////////////////////////////
         // Falling edge, drive the ports
         ////////////////////////////////////////////////
         @(negedge dram_clk);
         o_wr_req_ready  = (wr_state == S_IDLE) && !i_flush;
         o_wr_data_ready = (wr_state == S_DATA);
         o_wr_done       = (wr_state == S_DONE);
         o_rd_req_ready  = (rd_state == S_IDLE) && !i_flush;
         o_rd_data_valid = (rd_state == S_DATA);
         o_rd_done       = (rd_state == S_DONE);
         if (rd_state == S_DATA) begin
            rd_index = (rd_cur.addr >> `DF_WORD_SHIFT) + `DF_AWIDTH'(rd_beats);
            if (mem.exists(rd_index)) o_rd_data = mem[rd_index];
            else o_miss = 1'b1;                     // Read ahead of the writes
         end
      end
   end

endmodule

// ==== verif/tb_dram_fifo.sv ====
// Testbench for the DRAM FIFO with a burst memory model
// Inputs change on the falling edge and transfers are sampled on the rising edge
// Uses the reset settings with a 2048 word ring at address 0
`timescale 1ns/1ps
`include "dram_fifo_consts.svh"

module tb_dram_fifo import dram_fifo_pkg::*; ();

   logic                  dram_clk;
   logic                  input_timeout_reset;
   set_bus_t              i_set;
   logic [31:0]           o_rb_data;
   logic [`DF_DWIDTH-1:0] i_in_data;
   logic                  i_in_valid;
   logic                  o_in_ready;
   logic [`DF_DWIDTH-1:0] o_out_data;
   logic                  o_out_valid;
   logic                  i_out_ready;
   burst_req_t            wr_req;
   burst_req_t            rd_req;
   logic                  wr_req_valid;
   logic                  wr_req_ready;
   logic                  wr_data_valid;
   logic                  wr_data_ready;
   logic                  wr_done;
   logic                  rd_req_valid;
   logic                  rd_req_ready;
   logic                  rd_data_valid;
   logic                  rd_data_ready;
   logic                  rd_done;
   logic [`DF_DWIDTH-1:0] wr_data;
   logic [`DF_DWIDTH-1:0] rd_data;
   logic                  mem_miss;
   logic                  flush;                 // Model drops bursts
   logic                  clearing;              // Reference queue emptied
   logic [`DF_DWIDTH-1:0] ref_q [$];             // Words inside the DUT with the oldest first
   logic [31:0]           rng;

   dram_fifo_top dut0 (
      .dram_clk(dram_clk), .input_timeout_reset(input_timeout_reset),
      .i_set(i_set), .o_rb_data(o_rb_data),
      .i_in_data(i_in_data), .i_in_valid(i_in_valid), .o_in_ready(o_in_ready),
      .o_out_data(o_out_data), .o_out_valid(o_out_valid), .i_out_ready(i_out_ready),
      .o_wr_req(wr_req), .o_wr_req_valid(wr_req_valid), .i_wr_req_ready(wr_req_ready),
      .o_wr_data(wr_data), .o_wr_data_valid(wr_data_valid), .i_wr_data_ready(wr_data_ready),
      .i_wr_done(wr_done),
      .o_rd_req(rd_req), .o_rd_req_valid(rd_req_valid), .i_rd_req_ready(rd_req_ready),
      .i_rd_data(rd_data), .i_rd_data_valid(rd_data_valid), .o_rd_data_ready(rd_data_ready),
      .i_rd_done(rd_done)
   );

   dram_model mem0 (
      .dram_clk(dram_clk), .i_flush(flush),
      .i_wr_req(wr_req), .i_wr_req_valid(wr_req_valid), .o_wr_req_ready(wr_req_ready),
      .i_wr_data(wr_data), .i_wr_data_valid(wr_data_valid), .o_wr_data_ready(wr_data_ready),
      .o_wr_done(wr_done),
      .i_rd_req(rd_req), .i_rd_req_valid(rd_req_valid), .o_rd_req_ready(rd_req_ready),
      .o_rd_data(rd_data), .o_rd_data_valid(rd_data_valid), .i_rd_data_ready(rd_data_ready),
      .o_rd_done(rd_done), .o_miss(mem_miss)
   );

   initial begin : clock_gen
      dram_clk = 1'b0;
      forever #4 dram_clk = ~dram_clk;   // 8 ns period
   end

   //////////////////////////////////////////////////
   // Helpers
   //////////////////////////////////////////////////
   task automatic abort_run(input string why);
      $display("%s", why);
      $display("Test failed");
      $fatal(1, "Stopped at the first error");
   endtask

   function automatic logic [31:0] xorshift32(input logic [31:0] x);
      logic [31:0] y;
      y = x ^ (x << 13);
      y = y ^ (y >> 17);
      return y ^ (y << 5);
   endfunction

   function automatic logic [`DF_DWIDTH-1:0] next_word();
      logic [31:0] hi;
      rng = xorshift32(rng);
      hi  = rng;
      rng = xorshift32(rng);
      return {hi, rng};
   endfunction

   // Reference model keeps arrival order so the oldest word comes out next
   function automatic logic [`DF_DWIDTH-1:0] expected_word();
      return ref_q.pop_front();
   endfunction

   function automatic logic [31:0] ctrl_word(input logic clear);
      return {16'd0, `DF_DEFAULT_TIMEOUT, 3'd0, clear};   // Timeout in bits 15:4
   endfunction

   task automatic write_setting(input logic [7:0] addr, input logic [31:0] data);
      @(negedge dram_clk);
      i_set.stb  = 1'b1;
      i_set.addr = addr;
      i_set.data = data;
      @(negedge dram_clk);
      i_set.stb  = 1'b0;
   endtask

   // Gap cycles first and then the word is held until it is taken
   task automatic send_word(input logic [`DF_DWIDTH-1:0] w, input int gap);
      int waited;
      waited = 0;
      repeat (gap) begin
         @(negedge dram_clk);
         i_in_valid = 1'b0;
      end
      @(negedge dram_clk);
      i_in_data  = w;
      i_in_valid = 1'b1;
      @(posedge dram_clk);
      while (!o_in_ready) begin
         waited++;
         assert (waited < 5000) else abort_run("input stayed refused while sending a word");
         @(posedge dram_clk);
      end
   endtask

   task automatic stop_input();
      @(negedge dram_clk);
      i_in_valid = 1'b0;
   endtask

   task automatic wait_drained(input int limit);
      int waited;
      waited = 0;
      @(negedge dram_clk);
      while (ref_q.size() != 0) begin
         waited++;
         assert (waited < limit) else
            abort_run($sformatf("%0d words never came out", ref_q.size()));
         @(negedge dram_clk);
      end
   endtask

   // Push with the output held until the input refuses a word
   task automatic fill_until_refused();
      int  sent;
      logic refused;
      sent    = 0;
      refused = 1'b0;
      @(negedge dram_clk);
      i_out_ready = 1'b0;
      i_in_data   = next_word();
      i_in_valid  = 1'b1;
      while (!refused) begin
         @(posedge dram_clk);
         if (o_in_ready) begin
            sent++;
            assert (sent < 8000) else abort_run("input was never refused with the output held");
            @(negedge dram_clk);
            i_in_data = next_word();
         end else begin
            refused = 1'b1;                        // Last word was not taken
         end
      end
      @(negedge dram_clk);
      i_in_valid  = 1'b0;
      i_out_ready = 1'b1;
   endtask

   task automatic check_burst(input burst_req_t r, input string port);
      logic [9:0] last_word;   // Offset of the final word in its page
      logic [`DF_AWIDTH-1:0] ring;
      ring      = `DF_DEFAULT_BASE & `DF_DEFAULT_MASK;
      last_word = {1'b0, r.addr[`DF_PAGE_SHIFT-1:`DF_WORD_SHIFT]} + {2'b0, r.count};
      assert (last_word < 10'd512) else
         abort_run($sformatf("%s burst at %h crosses a 4 KiB page", port, r.addr));
      assert (r.addr[`DF_WORD_SHIFT-1:0] == '0) else
         abort_run($sformatf("%s burst address %h is not word aligned", port, r.addr));
      assert ((r.addr & `DF_DEFAULT_MASK) == ring) else
         abort_run($sformatf("MISMATCH %s req.addr fixed bits got %h expected %h",
                             port, r.addr & `DF_DEFAULT_MASK, ring));
   endtask

   task automatic scan_request_log();
      int wraps;
      wraps = 0;
      for (int k = 0; k < mem0.wr_log.size(); k++) begin
         check_burst(mem0.wr_log[k], "write");
         if (k > 0 && mem0.wr_log[k].addr <= mem0.wr_log[k-1].addr) wraps++;
      end
      for (int k = 0; k < mem0.rd_log.size(); k++) check_burst(mem0.rd_log[k], "read");
      assert (wraps > 0) else abort_run("write pointer never wrapped around the ring");
   endtask

   //////////////////////////////////////////////////
   // Comparing process
   //////////////////////////////////////////////////
   always @(posedge dram_clk) begin : compare_out
      logic [`DF_DWIDTH-1:0] exp_word;
      if (clearing) begin
         ref_q.delete();
      end else if (!input_timeout_reset) begin
         if (o_out_valid && i_out_ready) begin
            assert (ref_q.size() != 0) else abort_run("output word arrived with none outstanding");
            exp_word = expected_word();
            assert (o_out_data == exp_word) else
               abort_run($sformatf("MISMATCH o_out_data got %h expected %h", o_out_data, exp_word));
         end
         if (i_in_valid && o_in_ready) ref_q.push_back(i_in_data);   // Accepted word
      end
      assert (!mem_miss) else abort_run("memory model read a word that was never written");
   end

   //////////////////////////////////////////////////
   // Stimulus
   //////////////////////////////////////////////////
   initial begin : main
      rng                 = 32'd75545;
      input_timeout_reset = 1'b1;
      i_set               = '0;
      i_in_data           = '0;
      i_in_valid          = 1'b0;
      i_out_ready         = 1'b0;
      flush               = 1'b1;
      clearing            = 1'b0;
      repeat (16) @(negedge dram_clk);
      input_timeout_reset = 1'b0;
      flush               = 1'b0;
      i_out_ready         = 1'b1;

      // Quiet after reset with an empty ring in the readback
      assert (!o_out_valid && !wr_req_valid && !rd_req_valid) else
         abort_run("a valid output was high right after reset");
      assert (o_rb_data == 32'h8000_0000) else
         abort_run($sformatf("MISMATCH o_rb_data got %h expected %h", o_rb_data, 32'h8000_0000));

      // Long stream with random input gaps
      for (int i = 0; i < 3000; i++) send_word(next_word(), int'(rng & 32'd3));
      stop_input();
      wait_drained(40000);

      // Short fragment that only the timeout can move
      for (int i = 0; i < 5; i++) send_word(next_word(), 0);
      stop_input();
      wait_drained(5000);

      // Back-pressure all the way to the input
      fill_until_refused();
      wait_drained(40000);

      // Park words inside and then clear
      @(negedge dram_clk);
      i_out_ready = 1'b0;
      for (int i = 0; i < 600; i++) send_word(next_word(), 0);
      stop_input();
      flush    = 1'b1;
      clearing = 1'b1;
      write_setting(`DF_SR_CTRL, ctrl_word(1'b1));
      repeat (4) @(negedge dram_clk);
      assert (o_rb_data == 32'h8000_0000) else
         abort_run($sformatf("MISMATCH o_rb_data got %h expected %h", o_rb_data, 32'h8000_0000));
      assert (!o_out_valid && !wr_data_valid) else abort_run("clear left words in a staging FIFO");
      flush    = 1'b0;
      clearing = 1'b0;
      write_setting(`DF_SR_CTRL, ctrl_word(1'b0));
      i_out_ready = 1'b1;
      for (int i = 0; i < 300; i++) send_word(next_word(), int'(rng & 32'd1));
      stop_input();
      wait_drained(20000);

      scan_request_log();
      $display("Test completed successfully");
      $finish;
   end

endmodule

// ==== verilog/burst_scheduler.sv ====
// Burst scheduler, one for writes and one for reads
// Starts a burst when 256 words are ready or the timeout fires on a fragment
// No burst crosses a 4 KiB page
// Ring pointer advances only when the memory reports the burst done
`timescale 1ns/1ps
`include "dram_fifo_consts.svh"

module burst_scheduler import dram_fifo_pkg::*; (
   input  logic                   dram_clk,
   input  logic                   input_timeout_reset,
   input  fifo_cfg_t              i_cfg,
   input  logic [`DF_LEVEL_W-1:0] i_avail,     // Words waiting to move
   input  logic [`DF_LEVEL_W-1:0] i_room,      // Free words at the destination
   input  logic                   i_req_ready,
   input  logic                   i_done,      // One cycle per finished burst
   output burst_req_t             o_req,
   output logic                   o_req_valid,
   output logic                   o_commit,
   output logic [7:0]             o_commit_count
);

   localparam logic [2:0] S_IDLE   = 3'd0;
   localparam logic [2:0] S_SIZE   = 3'd1;   // Work out the length
   localparam logic [2:0] S_REQ    = 3'd2;   // Request held until accepted
   localparam logic [2:0] S_BUSY   = 3'd3;   // Waiting for done
   localparam logic [2:0] S_SETTLE = 3'd4;   // Lets the level counters catch up

   localparam int PAGE_W = `DF_PAGE_SHIFT - `DF_WORD_SHIFT;
   localparam logic [`DF_LEVEL_W-1:0] BURST   = `DF_BURST_WORDS;
   localparam logic [`DF_LEVEL_W-1:0] MAX_CNT = `DF_BURST_WORDS - 1;

   logic                     clr;
   logic [2:0]               state;
   logic [`DF_TIMEOUT_W-1:0] tmo_count;
   logic                     tmo_hit;
   logic                     full_trig;
   logic                     room_ok;
   logic                     go_full;
   logic                     go_tmo;
   logic [`DF_AWIDTH-1:0]    ptr;
   logic [`DF_AWIDTH-1:0]    step;
   logic [PAGE_W-1:0]        page_m1;
   logic [`DF_LEVEL_W-1:0]   avail_m1;
   logic [7:0]               lim;
   logic [7:0]               count_next;
   logic [7:0]               count_q;

   assign clr = input_timeout_reset | i_cfg.clear;

   //////////////////////////////////////////////////
   // Trigger
   //////////////////////////////////////////////////
   assign room_ok = (i_room >= BURST);
   assign go_full = room_ok && (i_avail >= BURST);
   assign go_tmo  = room_ok && tmo_hit && (i_avail != '0);   // Never an empty burst

   // Counts idle cycles with data waiting
   always_ff @(posedge dram_clk) begin
      if (clr || state != S_IDLE) begin
         tmo_count <= '0;
         tmo_hit   <= 1'b0;
      end else if (tmo_count == i_cfg.timeout) begin
         tmo_hit <= 1'b1;
      end else if (i_avail != '0) begin
         tmo_count <= tmo_count + 1'b1;
      end
   end

   //////////////////////////////////////////////////
   // Burst length
   //////////////////////////////////////////////////
   assign page_m1  = ~ptr[`DF_PAGE_SHIFT-1:`DF_WORD_SHIFT];   // Words to page end, minus one
   assign avail_m1 = i_avail - 1'b1;
   // More data may have arrived since a timeout so cap at a full burst
   assign lim = (full_trig || avail_m1 > MAX_CNT) ? 8'hFF : avail_m1[7:0];
   assign count_next = (page_m1 < PAGE_W'(lim)) ? page_m1[7:0] : lim;

   assign step = (`DF_AWIDTH'(count_q) + 1'b1) << `DF_WORD_SHIFT;   // Burst size in bytes

   always_ff @(posedge dram_clk) begin
      if (state == S_SIZE) count_q <= count_next;
   end

   //////////////////////////////////////////////////
   // FSM
   //////////////////////////////////////////////////
   always_ff @(posedge dram_clk) begin
      if (clr) begin
         state       <= S_IDLE;
         o_req_valid <= 1'b0;
         o_commit    <= 1'b0;
         full_trig   <= 1'b0;
         ptr         <= i_cfg.base & i_cfg.mask;   // Start of ring
      end else begin
         case (state)
            S_IDLE: begin
               if (go_full || go_tmo) begin
                  full_trig <= go_full;
                  state     <= S_SIZE;
               end
            end
            S_SIZE: begin
               o_req_valid <= 1'b1;
               state       <= S_REQ;
            end
            S_REQ: begin
               if (i_req_ready) begin
                  o_req_valid <= 1'b0;
                  state       <= S_BUSY;
               end
            end
            S_BUSY: begin
               if (i_done) begin
                  // Wrap in the free bits and keep the fixed ones
                  ptr      <= ((ptr + step) & ~i_cfg.mask) | (ptr & i_cfg.mask);
                  o_commit <= 1'b1;
                  state    <= S_SETTLE;
               end
            end
            S_SETTLE: begin
               o_commit <= 1'b0;
               state    <= S_IDLE;
            end
            default: state <= S_IDLE;
         endcase
      end
   end

   assign o_req.addr     = ptr;
   assign o_req.count    = count_q;
   assign o_commit_count = count_q;   // Stable through the commit pulse

endmodule

// ==== verilog/dram_fifo_consts.svh ====
// Constants for the DRAM FIFO
// The ring must span at least one 4 KiB page so the page limit also covers the wrap
// A burst moves at most 256 words of 8 bytes
`ifndef DRAM_FIFO_CONSTS_SVH
`define DRAM_FIFO_CONSTS_SVH

`define DF_DWIDTH        64       // Stream word width
`define DF_AWIDTH        30       // Byte address width
`define DF_WORD_SHIFT    3        // 8 bytes per word
`define DF_PAGE_SHIFT    12       // 4 KiB page
`define DF_BURST_WORDS   256      // Burst trigger level
`define DF_GUARD_WORDS   64       // Held back for reorder in the memory controller
`define DF_TIMEOUT_W     12
`define DF_LEVEL_W       27       // DRAM word count, up to 1 GiB
`define DF_STAGE_LOG2    10       // 1024 entry staging FIFOs

// Settings register addresses
`define DF_SR_CTRL       8'd0
`define DF_SR_BASE       8'd1
`define DF_SR_MASK       8'd2

// Reset values, 16 KiB ring at address 0
`define DF_DEFAULT_TIMEOUT  12'd256
`define DF_DEFAULT_BASE     30'h00000000
`define DF_DEFAULT_MASK     30'h3FFFC000

`endif

// ==== verilog/dram_fifo_pkg.sv ====
// Shared types for the DRAM FIFO
// Struct fields are listed MSB first
`include "dram_fifo_consts.svh"

package dram_fifo_pkg;

   // One write on the settings bus
   typedef struct packed {
      logic        stb;     // Write strobe
      logic [7:0]  addr;    // Register address
      logic [31:0] data;
   } set_bus_t;

   // Settings data, read as control or as address by register
   typedef union packed {
      struct packed {
         logic [15:0]              rsvd_hi;
         logic [`DF_TIMEOUT_W-1:0] timeout;   // Bits 15:4
         logic [2:0]               rsvd_lo;
         logic                     clear;     // Bit 0
      } ctrl;
      struct packed {
         logic [1:0]            unused;
         logic [`DF_AWIDTH-1:0] addr;
      } addr;
   } set_word_u;

   // Live configuration
   typedef struct packed {
      logic                     clear;
      logic [`DF_TIMEOUT_W-1:0] timeout;   // Cycles before a short burst
      logic [`DF_AWIDTH-1:0]    base;
      logic [`DF_AWIDTH-1:0]    mask;      // 1 = fixed address bit
   } fifo_cfg_t;

   typedef struct packed {
      logic [`DF_AWIDTH-1:0] addr;    // Byte address, word aligned
      logic [7:0]            count;   // Words minus one
   } burst_req_t;

   typedef struct packed {
      logic [`DF_DWIDTH-1:0] data;
      logic                  valid;
   } stream_beat_t;

endpackage

// ==== verilog/dram_fifo_top.sv ====
// DRAM-backed FIFO, single clock
// Words leave in the order they entered
// The memory behind the burst ports must keep each burst in order
`timescale 1ns/1ps
`include "dram_fifo_consts.svh"

module dram_fifo_top import dram_fifo_pkg::*; (
   input  logic                   dram_clk,
   input  logic                   input_timeout_reset,
   // Settings and readback
   input  set_bus_t               i_set,
   output logic [31:0]            o_rb_data,
   // Stream in
   input  logic [`DF_DWIDTH-1:0]  i_in_data,
   input  logic                   i_in_valid,
   output logic                   o_in_ready,
   // Stream out
   output logic [`DF_DWIDTH-1:0]  o_out_data,
   output logic                   o_out_valid,
   input  logic                   i_out_ready,
   // Memory write port
   output burst_req_t             o_wr_req,
   output logic                   o_wr_req_valid,
   input  logic                   i_wr_req_ready,
   output logic [`DF_DWIDTH-1:0]  o_wr_data,
   output logic                   o_wr_data_valid,
   input  logic                   i_wr_data_ready,
   input  logic                   i_wr_done,
   // Memory read port
   output burst_req_t             o_rd_req,
   output logic                   o_rd_req_valid,
   input  logic                   i_rd_req_ready,
   input  logic [`DF_DWIDTH-1:0]  i_rd_data,
   input  logic                   i_rd_data_valid,
   output logic                   o_rd_data_ready,
   input  logic                   i_rd_done
);

   fifo_cfg_t              cfg;
   logic [15:0]            in_occupied;     // Words staged for writing
   logic [15:0]            out_space;       // Room for read data
   logic [`DF_LEVEL_W-1:0] dram_occupied;
   logic [`DF_LEVEL_W-1:0] dram_space;
   logic                   wr_commit;
   logic [7:0]             wr_count;
   logic                   rd_commit;
   logic [7:0]             rd_count;

   fifo_settings settings (
      .dram_clk(dram_clk), .input_timeout_reset(input_timeout_reset),
      .i_set(i_set), .i_level(dram_occupied),
      .o_cfg(cfg), .o_rb_data(o_rb_data)
   );

   // Input staging, drained by write bursts
   stage_fifo #(.DEPTH_LOG2(`DF_STAGE_LOG2)) in_stage (
      .dram_clk(dram_clk), .input_timeout_reset(input_timeout_reset), .i_clear(cfg.clear),
      .i_data(i_in_data), .i_valid(i_in_valid), .o_ready(o_in_ready),
      .o_data(o_wr_data), .o_valid(o_wr_data_valid), .i_ready(i_wr_data_ready),
      .o_space(), .o_occupied(in_occupied)
   );

   // Output staging, filled by read bursts
   stage_fifo #(.DEPTH_LOG2(`DF_STAGE_LOG2)) out_stage (
      .dram_clk(dram_clk), .input_timeout_reset(input_timeout_reset), .i_clear(cfg.clear),
      .i_data(i_rd_data), .i_valid(i_rd_data_valid), .o_ready(o_rd_data_ready),
      .o_data(o_out_data), .o_valid(o_out_valid), .i_ready(i_out_ready),
      .o_space(out_space), .o_occupied()
   );

   burst_scheduler wr_sched (
      .dram_clk(dram_clk), .input_timeout_reset(input_timeout_reset), .i_cfg(cfg),
      .i_avail({{(`DF_LEVEL_W-16){1'b0}}, in_occupied}), .i_room(dram_space),
      .i_req_ready(i_wr_req_ready), .i_done(i_wr_done),
      .o_req(o_wr_req), .o_req_valid(o_wr_req_valid),
      .o_commit(wr_commit), .o_commit_count(wr_count)
   );

   burst_scheduler rd_sched (
      .dram_clk(dram_clk), .input_timeout_reset(input_timeout_reset), .i_cfg(cfg),
      .i_avail(dram_occupied), .i_room({{(`DF_LEVEL_W-16){1'b0}}, out_space}),
      .i_req_ready(i_rd_req_ready), .i_done(i_rd_done),
      .o_req(o_rd_req), .o_req_valid(o_rd_req_valid),
      .o_commit(rd_commit), .o_commit_count(rd_count)
   );

   fifo_level_tracker tracker (
      .dram_clk(dram_clk), .input_timeout_reset(input_timeout_reset), .i_cfg(cfg),
      .i_wr_commit(wr_commit), .i_wr_count(wr_count),
      .i_rd_commit(rd_commit), .i_rd_count(rd_count),
      .o_occupied(dram_occupied), .o_space(dram_space)
   );

endmodule

// ==== verilog/fifo_level_tracker.sv ====
// Occupied and free words of the DRAM ring
// Counts change the cycle after a commit pulse
// Free space starts at the ring size less the 64 word guard
`timescale 1ns/1ps
`include "dram_fifo_consts.svh"

module fifo_level_tracker import dram_fifo_pkg::*; (
   input  logic                   dram_clk,
   input  logic                   input_timeout_reset,
   input  fifo_cfg_t              i_cfg,
   input  logic                   i_wr_commit,
   input  logic [7:0]             i_wr_count,   // Words minus one
   input  logic                   i_rd_commit,
   input  logic [7:0]             i_rd_count,
   output logic [`DF_LEVEL_W-1:0] o_occupied,
   output logic [`DF_LEVEL_W-1:0] o_space
);

   logic [`DF_AWIDTH-1:0]  free_bits;    // Address bits the ring may use
   logic [`DF_LEVEL_W-1:0] init_space;
   logic [`DF_LEVEL_W-1:0] wr_words;
   logic [`DF_LEVEL_W-1:0] rd_words;

   assign free_bits = ~i_cfg.mask;
   // Ring words are the free word bits plus one
   assign init_space = free_bits[`DF_AWIDTH-1:`DF_WORD_SHIFT] -
                       `DF_LEVEL_W'(`DF_GUARD_WORDS - 1);

   assign wr_words = i_wr_commit ? `DF_LEVEL_W'(i_wr_count) + 1'b1 : '0;
   assign rd_words = i_rd_commit ? `DF_LEVEL_W'(i_rd_count) + 1'b1 : '0;

   always_ff @(posedge dram_clk) begin
      if (input_timeout_reset | i_cfg.clear) begin
         o_occupied <= '0;
         o_space    <= init_space;
      end else begin
         o_occupied <= o_occupied + wr_words - rd_words;
         o_space    <= o_space - wr_words + rd_words;   // Mirrors occupied
      end
   end

endmodule

// ==== verilog/fifo_settings.sv ====
// Settings registers and readback
// Writes land on the edge where the strobe is high
// Clear stays set until software writes it back to 0
`timescale 1ns/1ps
`include "dram_fifo_consts.svh"

module fifo_settings import dram_fifo_pkg::*; (
   input  logic                   dram_clk,
   input  logic                   input_timeout_reset,
   input  set_bus_t               i_set,
   input  logic [`DF_LEVEL_W-1:0] i_level,     // DRAM occupancy in words
   output fifo_cfg_t              o_cfg,
   output logic [31:0]            o_rb_data
);

   set_word_u wr_word;   // Same data seen as ctrl or addr

   assign wr_word = i_set.data;

   //////////////////////////////////////////////////
   // Register writes
   //////////////////////////////////////////////////
   always_ff @(posedge dram_clk) begin
      if (input_timeout_reset) begin
         o_cfg.clear   <= 1'b0;                 // Run straight out of reset
         o_cfg.timeout <= `DF_DEFAULT_TIMEOUT;
         o_cfg.base    <= `DF_DEFAULT_BASE;
         o_cfg.mask    <= `DF_DEFAULT_MASK;
      end else if (i_set.stb) begin
         case (i_set.addr)
            `DF_SR_CTRL: begin
               o_cfg.clear   <= wr_word.ctrl.clear;
               o_cfg.timeout <= wr_word.ctrl.timeout;
            end
            `DF_SR_BASE: o_cfg.base <= wr_word.addr.addr;
            `DF_SR_MASK: o_cfg.mask <= wr_word.addr.addr;
            default: ;                          // Other addresses belong elsewhere
         endcase
      end
   end

   // Readback
   // Bit 31 marks a DRAM FIFO
   // Low bits give the ring fill in words
   assign o_rb_data = {1'b1, {(31-`DF_LEVEL_W){1'b0}}, i_level};

endmodule

// ==== verilog/stage_fifo.sv ====
// Staging FIFO, register array with valid/ready on both sides
// Output word is read combinationally from the array
// DEPTH_LOG2 at most 15 so the counts fit 16 bits
`timescale 1ns/1ps
`include "dram_fifo_consts.svh"

module stage_fifo import dram_fifo_pkg::*; #(
   parameter int DEPTH_LOG2 = `DF_STAGE_LOG2
) (
   input  logic                  dram_clk,
   input  logic                  input_timeout_reset,
   input  logic                  i_clear,
   input  logic [`DF_DWIDTH-1:0] i_data,
   input  logic                  i_valid,
   output logic                  o_ready,
   output logic [`DF_DWIDTH-1:0] o_data,
   output logic                  o_valid,
   input  logic                  i_ready,
   output logic [15:0]           o_space,      // Free entries
   output logic [15:0]           o_occupied    // Used entries
);

   localparam int DEPTH = 2 ** DEPTH_LOG2;

   logic [`DF_DWIDTH-1:0] mem [DEPTH];
   logic [DEPTH_LOG2-1:0] wr_ptr;
   logic [DEPTH_LOG2-1:0] rd_ptr;
   logic [DEPTH_LOG2:0]   count;
   logic                  push;
   logic                  pop;
   stream_beat_t          head;    // Oldest entry

   assign push = i_valid & o_ready;
   assign pop  = head.valid & i_ready;

   always_ff @(posedge dram_clk) begin
      if (input_timeout_reset | i_clear) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (push) wr_ptr <= wr_ptr + 1'b1;   // Pointers wrap on their own
         if (pop)  rd_ptr <= rd_ptr + 1'b1;
         count <= count + (DEPTH_LOG2+1)'(push) - (DEPTH_LOG2+1)'(pop);
      end
   end

   always_ff @(posedge dram_clk) begin
      if (push) mem[wr_ptr] <= i_data;
   end

   assign head.data  = mem[rd_ptr];
   assign head.valid = (count != '0);

   assign o_data     = head.data;
   assign o_valid    = head.valid;
   assign o_ready    = (count != (DEPTH_LOG2+1)'(DEPTH));   // Full when count hits depth
   assign o_occupied = 16'(count);
   assign o_space    = 16'(DEPTH - count);

endmodule
